// File: project.f
+incdir+design
design/sacc_pkg.sv
design/link_adapter.sv
design/io_endpoint.sv
design/vdp_accel.sv
design/sacc_tile.sv
verif/sacc_tile_tb.sv

// File: verif/sacc_tile_tb.sv
`timescale 1ns/10ps
`include "sacc_consts.svh"

module sacc_tile_tb;

  localparam int req_flits_lp = $bits(sacc_pkg::io_req_pkt_s) / `SACC_FLIT_W;
  localparam int resp_flits_lp = $bits(sacc_pkg::io_resp_pkt_s) / `SACC_FLIT_W;
  localparam int wait_limit_lp = 200;  // Cycles per packet
  localparam int poll_limit_lp = 40;

  logic clk_i = 1'b0;
  logic rst_i;
  logic [`SACC_ID_W-1:0] tile_id_i;
  sacc_pkg::flit_link_s req_link_i;
  logic req_ready_o;
  sacc_pkg::flit_link_s resp_link_o;
  logic resp_ready_i;

  logic signed [`SACC_ELEM_W-1:0] model_a [`SACC_VEC_LEN];
  logic signed [`SACC_ELEM_W-1:0] model_b [`SACC_VEC_LEN];
  logic [`SACC_DATA_W-1:0] model_result;
  logic [`SACC_TAG_W-1:0] next_tag = '0;
  int check_errors = 0;
  int timeouts = 0;

  sacc_tile i_dut
    (.clk_i(clk_i)
     , .rst_i(rst_i)
     , .tile_id_i(tile_id_i)
     , .req_link_i(req_link_i)
     , .req_ready_o(req_ready_o)
     , .resp_link_o(resp_link_o)
     , .resp_ready_i(resp_ready_i)
     );

  always #2 clk_i = ~clk_i;

  task automatic end_run();
    $display("Errors: %0d mismatches, %0d timeouts", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  endtask

  task automatic give_up(input string what);
    $display("Timeout at %0t: %s", $time, what);
    timeouts++;
    end_run();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Reference model
  function automatic logic [`SACC_DATA_W-1:0] dot_model();
    logic [`SACC_DATA_W-1:0] sum;
    sum = '0;
    for (int i = 0; i < `SACC_VEC_LEN; i++)
      sum = sum + int'(model_a[i]) * int'(model_b[i]);  // Wraps at 32 bits
    return sum;
  endfunction

  function automatic logic [`SACC_DATA_W-1:0] sext(input logic [`SACC_ELEM_W-1:0] e);
    return {{(`SACC_DATA_W-`SACC_ELEM_W){e[`SACC_ELEM_W-1]}}, e};
  endfunction

  function automatic sacc_pkg::io_resp_pkt_s expect_resp(input sacc_pkg::io_req_pkt_s req
                                                        , input logic [`SACC_DATA_W-1:0] data);
    sacc_pkg::io_resp_pkt_s r;
    r.rsvd = '0;
    r.dest = req.src;  // Back to the requester
    r.src = tile_id_i;
    r.tag = req.tag;
    r.wr_ack = (req.op == sacc_pkg::e_io_wr);
    r.data = data;
    return r;
  endfunction

  function automatic logic [`SACC_ADDR_W-1:0] unmapped_addr();
    case ($urandom_range(2))
      0: return 8'h08 + 8'($urandom_range(7));
      1: return 8'h18 + 8'($urandom_range(7));
      default: return 8'h23 + 8'($urandom_range(8'hdc));
    endcase
  endfunction

  task automatic check_ack(input sacc_pkg::io_resp_pkt_s got
                           , input sacc_pkg::io_resp_pkt_s exp);
    if (got !== exp)
      begin
        check_errors++;
        $display("CHECK FAILED at %0t: write ack %h, expected %h", $time, got, exp);
      end
  endtask

  task automatic check_read(input sacc_pkg::io_resp_pkt_s got
                            , input sacc_pkg::io_resp_pkt_s exp);
    if (got !== exp)
      begin
        check_errors++;
        $display("CHECK FAILED at %0t: read response %h, expected %h", $time, got, exp);
      end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Link drivers
  task automatic send_req(input sacc_pkg::io_req_pkt_s pkt, input bit gaps);
    logic [$bits(sacc_pkg::io_req_pkt_s)-1:0] flat;
    int sent;
    int waited;
    flat = pkt;
    sent = 0;
    waited = 0;
    while (sent < req_flits_lp)
      begin
        @(negedge clk_i);
        req_link_i.v = 1'b0;
        if (!gaps || $urandom_range(3) != 0)
          begin
            req_link_i.v = 1'b1;
            req_link_i.data = flat[sent*`SACC_FLIT_W +: `SACC_FLIT_W];
            if (req_ready_o)
              sent++;  // Taken at the next rising edge
          end
        waited++;
        if (waited > wait_limit_lp)
          give_up("the tile stopped accepting request flits");
      end
    @(negedge clk_i);
    req_link_i.v = 1'b0;
  endtask

  task automatic collect_resp(output sacc_pkg::io_resp_pkt_s pkt);
    logic [$bits(sacc_pkg::io_resp_pkt_s)-1:0] flat;
    int got;
    int waited;
    flat = '0;
    got = 0;
    waited = 0;
    while (got < resp_flits_lp)
      begin
        @(negedge clk_i);
        resp_ready_i = ($urandom_range(2) != 0);
        if (resp_link_o.v && resp_ready_i)
          begin
            flat[got*`SACC_FLIT_W +: `SACC_FLIT_W] = resp_link_o.data;
            got++;
          end
        waited++;
        if (waited > wait_limit_lp)
          give_up("a response packet never completed");
      end
    pkt = flat;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Transactions
  task automatic make_req(input sacc_pkg::io_op_e op, input logic [`SACC_ADDR_W-1:0] addr
                          , input logic [`SACC_DATA_W-1:0] data
                          , output sacc_pkg::io_req_pkt_s req);
    req.op = op;
    req.addr = addr;
    req.data = data;
    req.src = `SACC_ID_W'($urandom);
    req.tag = next_tag;
    next_tag++;  // Tags follow issue order
  endtask

  task automatic transact(input sacc_pkg::io_req_pkt_s req, output sacc_pkg::io_resp_pkt_s resp);
    fork
      send_req(req, 1'b1);
      collect_resp(resp);
    join
  endtask

  // Second request follows the first without random gaps
  task automatic transact_pair(input sacc_pkg::io_req_pkt_s req1
                               , input sacc_pkg::io_req_pkt_s req2
                               , output sacc_pkg::io_resp_pkt_s resp1
                               , output sacc_pkg::io_resp_pkt_s resp2);
    fork
      begin
        send_req(req1, 1'b0);
        send_req(req2, 1'b0);
      end
      begin
        collect_resp(resp1);
        collect_resp(resp2);
      end
    join
  endtask

  task automatic transact_three(input sacc_pkg::io_req_pkt_s req1
                                , input sacc_pkg::io_req_pkt_s req2
                                , input sacc_pkg::io_req_pkt_s req3
                                , output sacc_pkg::io_resp_pkt_s resp1
                                , output sacc_pkg::io_resp_pkt_s resp2
                                , output sacc_pkg::io_resp_pkt_s resp3);
    fork
      begin
        send_req(req1, 1'b0);
        send_req(req2, 1'b0);
        send_req(req3, 1'b0);
      end
      begin
        collect_resp(resp1);
        collect_resp(resp2);
        collect_resp(resp3);
      end
    join
  endtask

  task automatic write_word(input logic [`SACC_ADDR_W-1:0] addr
                            , input logic [`SACC_DATA_W-1:0] data);
    sacc_pkg::io_req_pkt_s req;
    sacc_pkg::io_resp_pkt_s resp;
    make_req(sacc_pkg::e_io_wr, addr, data, req);
    transact(req, resp);
    check_ack(resp, expect_resp(req, '0));
  endtask

  task automatic write_operand(input logic [`SACC_ADDR_W-1:0] addr
                               , input logic [`SACC_DATA_W-1:0] data);
    write_word(addr, data);
    if (addr < `SACC_ADDR_B)
      model_a[addr - `SACC_ADDR_A] = data[`SACC_ELEM_W-1:0];
    else
      model_b[addr - `SACC_ADDR_B] = data[`SACC_ELEM_W-1:0];
  endtask

  task automatic read_check(input logic [`SACC_ADDR_W-1:0] addr
                            , input logic [`SACC_DATA_W-1:0] exp);
    sacc_pkg::io_req_pkt_s req;
    sacc_pkg::io_resp_pkt_s resp;
    make_req(sacc_pkg::e_io_rd, addr, $urandom, req);
    transact(req, resp);
    check_read(resp, expect_resp(req, exp));
  endtask

  task automatic read_status(output logic [`SACC_DATA_W-1:0] status);
    sacc_pkg::io_req_pkt_s req;
    sacc_pkg::io_resp_pkt_s resp;
    make_req(sacc_pkg::e_io_rd, `SACC_ADDR_STATUS, '0, req);
    transact(req, resp);
    // Busy or done, never both or neither
    check_read(resp, expect_resp(req, resp.data[0] ? 32'h1 : 32'h2));
    status = resp.data;
  endtask

  task automatic wait_done();
    logic [`SACC_DATA_W-1:0] status;
    int polls;
    status = '0;
    polls = 0;
    while (status[1] !== 1'b1)
      begin
        read_status(status);
        polls++;
        if (polls > poll_limit_lp)
          give_up("the done flag never came up");
      end
  endtask

  task automatic check_all_readable();
    for (int i = 0; i < `SACC_VEC_LEN; i++)
      begin
        read_check(`SACC_ADDR_A + 8'(i), sext(model_a[i]));
        read_check(`SACC_ADDR_B + 8'(i), sext(model_b[i]));
      end
    read_check(`SACC_ADDR_RESULT, model_result);
    read_check(`SACC_ADDR_STATUS, 32'h2);  // Done, idle
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Main sequence
  initial
    begin
      sacc_pkg::io_req_pkt_s req_a;
      sacc_pkg::io_req_pkt_s req_b;
      sacc_pkg::io_req_pkt_s req_c;
      sacc_pkg::io_resp_pkt_s resp_a;
      sacc_pkg::io_resp_pkt_s resp_b;
      sacc_pkg::io_resp_pkt_s resp_c;
      int idx;
      void'($urandom(32'h6d9ed951));
      rst_i = 1'b1;
      req_link_i = '0;
      resp_ready_i = 1'b0;
      tile_id_i = `SACC_ID_W'($urandom);
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;

      for (int round = 0; round < 4; round++)
        begin
          for (int i = 0; i < `SACC_VEC_LEN; i++)
            begin
              write_operand(`SACC_ADDR_A + 8'(i), $urandom);
              write_operand(`SACC_ADDR_B + 8'(i), $urandom);
            end
          repeat (6)
            write_operand(($urandom_range(1) ? `SACC_ADDR_B : `SACC_ADDR_A)
                          + 8'($urandom_range(`SACC_VEC_LEN - 1)), $urandom);
          repeat (4)
            begin
              idx = $urandom_range(`SACC_VEC_LEN - 1);
              read_check(`SACC_ADDR_A + 8'(idx), sext(model_a[idx]));
              read_check(`SACC_ADDR_B + 8'(idx), sext(model_b[idx]));
            end
          write_word(`SACC_ADDR_START, $urandom);
          wait_done();
          model_result = dot_model();
          read_check(`SACC_ADDR_RESULT, model_result);
        end

      // Status read lands inside the MAC run
      make_req(sacc_pkg::e_io_wr, `SACC_ADDR_START, '0, req_a);
      make_req(sacc_pkg::e_io_rd, `SACC_ADDR_STATUS, '0, req_b);
      transact_pair(req_a, req_b, resp_a, resp_b);
      check_ack(resp_a, expect_resp(req_a, '0));
      check_read(resp_b, expect_resp(req_b, 32'h1));
      wait_done();
      read_check(`SACC_ADDR_RESULT, model_result);

      // Second start arrives while busy, so the first run ends on time
      make_req(sacc_pkg::e_io_wr, `SACC_ADDR_START, '0, req_a);
      make_req(sacc_pkg::e_io_wr, `SACC_ADDR_START, $urandom, req_b);
      make_req(sacc_pkg::e_io_rd, `SACC_ADDR_STATUS, '0, req_c);
      transact_three(req_a, req_b, req_c, resp_a, resp_b, resp_c);
      check_ack(resp_a, expect_resp(req_a, '0));
      check_ack(resp_b, expect_resp(req_b, '0));
      check_read(resp_c, expect_resp(req_c, 32'h2));
      wait_done();
      read_check(`SACC_ADDR_RESULT, model_result);

      repeat (6)
        read_check(unmapped_addr(), '0);
      repeat (3)
        write_word(unmapped_addr(), $urandom);
      check_all_readable();

      end_run();
    end

endmodule

// File: design/sacc_tile.sv
`timescale 1ns/10ps
`include "sacc_consts.svh"

module sacc_tile
  (input clk_i
   , input rst_i

   , input [`SACC_ID_W-1:0] tile_id_i

   , input sacc_pkg::flit_link_s req_link_i
   , output logic req_ready_o

   , output sacc_pkg::flit_link_s resp_link_o
   , input resp_ready_i
   );

  logic rst_r;

  sacc_pkg::io_req_pkt_s req_pkt_lo;
  logic req_v_lo, req_yumi_li;
  sacc_pkg::io_resp_pkt_s resp_pkt_li;
  logic resp_v_li, resp_ready_lo;

  sacc_pkg::io_cmd_s io_cmd_lo;
  logic io_cmd_v_lo, io_cmd_ready_li;
  sacc_pkg::io_reply_s io_reply_li;
  logic io_reply_v_li, io_reply_yumi_lo;

  always_ff @(posedge clk_i)
    rst_r <= rst_i;  // Shared by all blocks

  link_adapter
    #(.in_pkt_t(sacc_pkg::io_req_pkt_s)
      , .out_pkt_t(sacc_pkg::io_resp_pkt_s)
      )
    i_link
    (.clk_i(clk_i)
     , .rst_i(rst_r)
     , .link_i(req_link_i)
     , .link_ready_o(req_ready_o)
     , .link_o(resp_link_o)
     , .link_ready_i(resp_ready_i)
     , .pkt_o(req_pkt_lo)
     , .pkt_v_o(req_v_lo)
     , .pkt_yumi_i(req_yumi_li)
     , .pkt_i(resp_pkt_li)
     , .pkt_v_i(resp_v_li)
     , .pkt_ready_o(resp_ready_lo)
     );

  io_endpoint i_endpoint
    (.clk_i(clk_i)
     , .rst_i(rst_r)
     , .tile_id_i(tile_id_i)
     , .req_pkt_i(req_pkt_lo)
     , .req_v_i(req_v_lo)
     , .req_yumi_o(req_yumi_li)
     , .resp_pkt_o(resp_pkt_li)
     , .resp_v_o(resp_v_li)
     , .resp_ready_i(resp_ready_lo)
     , .io_cmd_o(io_cmd_lo)
     , .io_cmd_v_o(io_cmd_v_lo)
     , .io_cmd_ready_i(io_cmd_ready_li)
     , .io_reply_i(io_reply_li)
     , .io_reply_v_i(io_reply_v_li)
     , .io_reply_yumi_o(io_reply_yumi_lo)
     );

  vdp_accel i_vdp
    (.clk_i(clk_i)
     , .rst_i(rst_r)
     , .io_cmd_i(io_cmd_lo)
     , .io_cmd_v_i(io_cmd_v_lo)
     , .io_cmd_ready_o(io_cmd_ready_li)
     , .io_reply_o(io_reply_li)
     , .io_reply_v_o(io_reply_v_li)
     , .io_reply_yumi_i(io_reply_yumi_lo)
     );

endmodule

// File: design/vdp_accel.sv
`timescale 1ns/10ps
`include "sacc_consts.svh"

module vdp_accel
  (input clk_i
   , input rst_i

   , input sacc_pkg::io_cmd_s io_cmd_i
   , input io_cmd_v_i
   , output logic io_cmd_ready_o

   , output sacc_pkg::io_reply_s io_reply_o
   , output logic io_reply_v_o
   , input io_reply_yumi_i
   );

  localparam int idx_w_lp = $clog2(`SACC_VEC_LEN);

  logic signed [`SACC_ELEM_W-1:0] vec_a_r [`SACC_VEC_LEN];
  logic signed [`SACC_ELEM_W-1:0] vec_b_r [`SACC_VEC_LEN];
  logic [idx_w_lp-1:0] idx_r;
  logic busy_r, done_r;
  logic [`SACC_DATA_W-1:0] acc_r;
  logic signed [2*`SACC_ELEM_W-1:0] prod;

  logic cmd_fire, is_wr, start_go;
  logic [`SACC_ADDR_W-1:0] a_off, b_off;
  logic hit_a, hit_b, hit_start, hit_status, hit_result;
  logic [`SACC_DATA_W-1:0] rd_data;
  logic reply_v_r;
  logic [`SACC_DATA_W-1:0] reply_data_r;

  // ~~~~~~~~~~~~~~~~~~~~
  // Command decode
  assign cmd_fire = io_cmd_v_i & io_cmd_ready_o;
  assign is_wr = (io_cmd_i.op == sacc_pkg::e_io_wr);
  assign a_off = io_cmd_i.addr - `SACC_ADDR_A;
  assign b_off = io_cmd_i.addr - `SACC_ADDR_B;
  assign hit_a = (a_off < `SACC_VEC_LEN);
  assign hit_b = (b_off < `SACC_VEC_LEN);
  assign hit_start = (io_cmd_i.addr == `SACC_ADDR_START);
  assign hit_status = (io_cmd_i.addr == `SACC_ADDR_STATUS);
  assign hit_result = (io_cmd_i.addr == `SACC_ADDR_RESULT);
  assign start_go = cmd_fire & is_wr & hit_start & ~busy_r;  // Ignored while busy

  always_comb
    begin
      rd_data = '0;  // Unmapped reads
      if (hit_a)
        rd_data = `SACC_DATA_W'(vec_a_r[a_off[idx_w_lp-1:0]]);
      else if (hit_b)
        rd_data = `SACC_DATA_W'(vec_b_r[b_off[idx_w_lp-1:0]]);
      else if (hit_status)
        rd_data = {{(`SACC_DATA_W-2){1'b0}}, done_r, busy_r};
      else if (hit_result)
        rd_data = acc_r;
    end

  always_ff @(posedge clk_i)
    if (cmd_fire && is_wr)
      begin
        if (hit_a)
          vec_a_r[a_off[idx_w_lp-1:0]] <= io_cmd_i.data[`SACC_ELEM_W-1:0];
        else if (hit_b)
          vec_b_r[b_off[idx_w_lp-1:0]] <= io_cmd_i.data[`SACC_ELEM_W-1:0];
      end

  // ~~~~~~~~~~~~~~~~~~~~
  // MAC loop
  assign prod = vec_a_r[idx_r] * vec_b_r[idx_r];

  always_ff @(posedge clk_i)
    if (rst_i)
      begin
        busy_r <= 1'b0;
        done_r <= 1'b0;
        idx_r <= '0;
        acc_r <= '0;
      end
    else if (start_go)
      begin
        busy_r <= 1'b1;
        done_r <= 1'b0;
        idx_r <= '0;
        acc_r <= '0;
      end
    else if (busy_r)
      begin
        acc_r <= acc_r + `SACC_DATA_W'(prod);  // 32-bit wrap
        idx_r <= idx_r + 1'b1;
        if (idx_r == idx_w_lp'(`SACC_VEC_LEN - 1))
          begin
            busy_r <= 1'b0;
            done_r <= 1'b1;
          end
      end

  // ~~~~~~~~~~~~~~~~~~~~
  // Reply
  assign io_cmd_ready_o = ~reply_v_r;

  always_ff @(posedge clk_i)
    if (rst_i)
      reply_v_r <= 1'b0;
    else
      reply_v_r <= cmd_fire | (reply_v_r & ~io_reply_yumi_i);

  always_ff @(posedge clk_i)
    if (cmd_fire)
      reply_data_r <= is_wr ? '0 : rd_data;

  assign io_reply_v_o = reply_v_r;
  assign io_reply_o = '{data: reply_data_r};

  assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(busy_r) |-> busy_r [*`SACC_VEC_LEN] ##1 !busy_r);

endmodule

// File: design/io_endpoint.sv
`timescale 1ns/10ps
`include "sacc_consts.svh"

module io_endpoint
  (input clk_i
   , input rst_i

   , input [`SACC_ID_W-1:0] tile_id_i

   , input sacc_pkg::io_req_pkt_s req_pkt_i
   , input req_v_i
   , output logic req_yumi_o

   , output sacc_pkg::io_resp_pkt_s resp_pkt_o
   , output logic resp_v_o
   , input resp_ready_i

   , output sacc_pkg::io_cmd_s io_cmd_o
   , output logic io_cmd_v_o
   , input io_cmd_ready_i

   , input sacc_pkg::io_reply_s io_reply_i
   , input io_reply_v_i
   , output logic io_reply_yumi_o
   );

  typedef enum logic [1:0] {e_idle, e_wait_reply, e_send_resp} state_e;

  state_e state_r, state_n;
  sacc_pkg::io_op_e op_r;
  logic [`SACC_ID_W-1:0] src_r;
  logic [`SACC_TAG_W-1:0] tag_r;
  logic [`SACC_DATA_W-1:0] data_r;
  logic cmd_fire;

  assign io_cmd_v_o = (state_r == e_idle) & req_v_i;
  assign io_cmd_o = '{op: req_pkt_i.op, addr: req_pkt_i.addr, data: req_pkt_i.data};
  assign cmd_fire = io_cmd_v_o & io_cmd_ready_i;
  assign req_yumi_o = cmd_fire;  // Request consumed as it goes out
  assign io_reply_yumi_o = (state_r == e_wait_reply) & io_reply_v_i;
  assign resp_v_o = (state_r == e_send_resp);

  // Reply returns to whoever asked
  assign resp_pkt_o = '{rsvd: '0
                        , dest: src_r
                        , src: tile_id_i
                        , tag: tag_r
                        , wr_ack: (op_r == sacc_pkg::e_io_wr)
                        , data: data_r
                        };

  always_comb
    begin
      state_n = state_r;
      case (state_r)
        e_idle:
          if (cmd_fire)
            state_n = e_wait_reply;
        e_wait_reply:
          if (io_reply_yumi_o)
            state_n = e_send_resp;
        e_send_resp:
          if (resp_ready_i)
            state_n = e_idle;
        default:
          state_n = e_idle;
      endcase
    end

  always_ff @(posedge clk_i)
    if (rst_i)
      state_r <= e_idle;
    else
      state_r <= state_n;

  always_ff @(posedge clk_i)
    begin
      if (cmd_fire)
        begin
          op_r <= req_pkt_i.op;
          src_r <= req_pkt_i.src;
          tag_r <= req_pkt_i.tag;
        end
      if (io_reply_yumi_o)
        data_r <= io_reply_i.data;
    end

  // One command in flight until its reply is taken
  assert property (@(posedge clk_i) disable iff (rst_i)
    io_cmd_v_o |-> !io_reply_v_i);

endmodule

// File: design/link_adapter.sv
`timescale 1ns/10ps
`include "sacc_consts.svh"

module link_adapter
  #(parameter type in_pkt_t = logic [`SACC_FLIT_W-1:0]
    , parameter type out_pkt_t = logic [`SACC_FLIT_W-1:0]
    )
  (input clk_i
   , input rst_i

   , input sacc_pkg::flit_link_s link_i
   , output logic link_ready_o

   , output sacc_pkg::flit_link_s link_o
   , input link_ready_i

   , output in_pkt_t pkt_o
   , output logic pkt_v_o
   , input pkt_yumi_i

   , input out_pkt_t pkt_i
   , input pkt_v_i
   , output logic pkt_ready_o
   );

  localparam int in_w_lp = $bits(in_pkt_t);
  localparam int in_flits_lp = (in_w_lp + `SACC_FLIT_W - 1) / `SACC_FLIT_W;
  localparam int in_sr_w_lp = in_flits_lp * `SACC_FLIT_W;
  localparam int in_cnt_w_lp = $clog2(in_flits_lp + 1);
  localparam int out_w_lp = $bits(out_pkt_t);
  localparam int out_flits_lp = (out_w_lp + `SACC_FLIT_W - 1) / `SACC_FLIT_W;
  localparam int out_sr_w_lp = out_flits_lp * `SACC_FLIT_W;
  localparam int out_cnt_w_lp = $clog2(out_flits_lp + 1);

  logic [in_sr_w_lp-1:0] in_sr_r;
  logic [in_cnt_w_lp-1:0] in_cnt_r;
  logic in_ready_r, pkt_v_r, pkt_v_n;
  logic in_fire, in_last;

  logic [out_sr_w_lp-1:0] out_sr_r;
  logic [out_cnt_w_lp-1:0] out_cnt_r;
  logic out_busy_r;
  logic out_load, out_fire;

  // ~~~~~~~~~~~~~~~~~~~~
  // Deserializer
  assign in_fire = link_i.v & in_ready_r;
  assign in_last = in_fire & (in_cnt_r == in_cnt_w_lp'(in_flits_lp - 1));
  assign pkt_v_n = in_last | (pkt_v_r & ~pkt_yumi_i);

  always_ff @(posedge clk_i)
    if (in_fire)
      in_sr_r <= {link_i.data, in_sr_r[in_sr_w_lp-1:`SACC_FLIT_W]};  // Newest flit on top

  always_ff @(posedge clk_i)
    if (rst_i)
      begin
        in_cnt_r <= '0;
        pkt_v_r <= 1'b0;
        in_ready_r <= 1'b0;
      end
    else
      begin
        if (in_last)
          in_cnt_r <= '0;
        else if (in_fire)
          in_cnt_r <= in_cnt_r + 1'b1;
        pkt_v_r <= pkt_v_n;
        in_ready_r <= ~pkt_v_n;  // Back-pressure while a packet waits
      end

  assign pkt_o = in_sr_r[in_w_lp-1:0];
  assign pkt_v_o = pkt_v_r;
  assign link_ready_o = in_ready_r;

  // ~~~~~~~~~~~~~~~~~~~~
  // Serializer
  assign pkt_ready_o = ~out_busy_r;
  assign out_load = pkt_v_i & pkt_ready_o;
  assign out_fire = out_busy_r & link_ready_i;

  always_ff @(posedge clk_i)
    if (out_load)
      out_sr_r <= out_sr_w_lp'(pkt_i);
    else if (out_fire)
      out_sr_r <= out_sr_r >> `SACC_FLIT_W;

  always_ff @(posedge clk_i)
    if (rst_i)
      begin
        out_busy_r <= 1'b0;
        out_cnt_r <= '0;
      end
    else if (out_load)
      begin
        out_busy_r <= 1'b1;
        out_cnt_r <= '0;
      end
    else if (out_fire)
      begin
        if (out_cnt_r == out_cnt_w_lp'(out_flits_lp - 1))
          out_busy_r <= 1'b0;
        out_cnt_r <= out_cnt_r + 1'b1;
      end

  assign link_o.v = out_busy_r;
  assign link_o.data = out_sr_r[`SACC_FLIT_W-1:0];

  // Consumer handshake rules
  assert property (@(posedge clk_i) disable iff (rst_i)
    pkt_v_o && !pkt_yumi_i |=> pkt_v_o && $stable(pkt_o));
  assert property (@(posedge clk_i) disable iff (rst_i) pkt_yumi_i |-> pkt_v_o);

endmodule

// File: design/sacc_pkg.sv
`include "sacc_consts.svh"

package sacc_pkg;

  typedef enum logic
  {
    e_io_rd = 1'b0
    , e_io_wr = 1'b1
  } io_op_e;

  // ~~~~~~~~~~~~~~~~~~~~
  // Network packets, flit 0 is the LSB end

  // 48 bits, 6 flits
  typedef struct packed
  {
    io_op_e op;
    logic [`SACC_ADDR_W-1:0] addr;
    logic [`SACC_DATA_W-1:0] data;
    logic [`SACC_ID_W-1:0] src;
    logic [`SACC_TAG_W-1:0] tag;
  } io_req_pkt_s;

  // Header plus data is 44 bits, so the top nibble pads it to whole flits
  typedef struct packed
  {
    logic [3:0] rsvd;
    logic [`SACC_ID_W-1:0] dest;
    logic [`SACC_ID_W-1:0] src;
    logic [`SACC_TAG_W-1:0] tag;
    logic wr_ack;
    logic [`SACC_DATA_W-1:0] data;
  } io_resp_pkt_s;

  // ~~~~~~~~~~~~~~~~~~~~
  // Local I/O side
  typedef struct packed
  {
    io_op_e op;
    logic [`SACC_ADDR_W-1:0] addr;
    logic [`SACC_DATA_W-1:0] data;
  } io_cmd_s;

  typedef struct packed
  {
    logic [`SACC_DATA_W-1:0] data;
  } io_reply_s;

  typedef struct packed
  {
    logic v;
    logic [`SACC_FLIT_W-1:0] data;
  } flit_link_s;

endpackage

// File: design/sacc_consts.svh
`ifndef SACC_CONSTS_SVH
`define SACC_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Link and packet sizes
`define SACC_FLIT_W 8
`define SACC_ID_W 4
`define SACC_TAG_W 3
`define SACC_ADDR_W 8
`define SACC_DATA_W 32

// ~~~~~~~~~~~~~~~~~~~~
// Accelerator sizes
`define SACC_VEC_LEN 8
`define SACC_ELEM_W 16

// ~~~~~~~~~~~~~~~~~~~~
// Address map
`define SACC_ADDR_A 8'h00  // 8 words of vector A
`define SACC_ADDR_B 8'h10  // 8 words of vector B
`define SACC_ADDR_START 8'h20
`define SACC_ADDR_STATUS 8'h21  // bit 0 busy, bit 1 done
`define SACC_ADDR_RESULT 8'h22

`endif
